// File: common/lcc_state_pkg.sv
// Lifecycle state encoding and enable token values, imported by the decode and control blocks
`default_nettype none

package lcc_state_pkg;

  // ----------------------------------------
  // Lifecycle states
  // ----------------------------------------

  // Compact 5-bit encoding, test states interleaved in fuse order
  typedef enum logic [4:0] {
    LcStRaw           = 5'd0,
    LcStTestUnlocked0 = 5'd1,
    LcStTestLocked0   = 5'd2,
    LcStTestUnlocked1 = 5'd3,
    LcStTestLocked1   = 5'd4,
    LcStTestUnlocked2 = 5'd5,
    LcStTestLocked2   = 5'd6,
    LcStTestUnlocked3 = 5'd7,
    LcStTestLocked3   = 5'd8,
    LcStTestUnlocked4 = 5'd9,
    LcStTestLocked4   = 5'd10,
    LcStTestUnlocked5 = 5'd11,
    LcStTestLocked5   = 5'd12,
    LcStTestUnlocked6 = 5'd13,
    LcStTestLocked6   = 5'd14,
    LcStTestUnlocked7 = 5'd15,
    LcStDev           = 5'd16,
    LcStProd          = 5'd17,
    LcStProdEnd       = 5'd18,
    LcStRma           = 5'd19,
    LcStScrap         = 5'd20
  } lc_state_e;

  // Any of the eight debug-open test states
  function automatic logic lc_is_test_unlocked(lc_state_e st);
    return st inside {LcStTestUnlocked0, LcStTestUnlocked1, LcStTestUnlocked2,
                      LcStTestUnlocked3, LcStTestUnlocked4, LcStTestUnlocked5,
                      LcStTestUnlocked6, LcStTestUnlocked7};
  endfunction

  // Any of the seven locked test states
  function automatic logic lc_is_test_locked(lc_state_e st);
    return st inside {LcStTestLocked0, LcStTestLocked1, LcStTestLocked2,
                      LcStTestLocked3, LcStTestLocked4, LcStTestLocked5,
                      LcStTestLocked6};
  endfunction

  // ----------------------------------------
  // Enable tokens
  // ----------------------------------------

  // Multi-bit token, only the exact On pattern enables
  typedef logic [3:0] lc_tx_t;
  localparam lc_tx_t LcTxOn  = 4'b0101;
  localparam lc_tx_t LcTxOff = 4'b1010;

endpackage

`default_nettype wire

// File: common/security_pkg.sv
// Security state types, translator FSM encoding and width defaults for the translator design
`default_nettype none

package security_pkg;

  // ----------------------------------------
  // Core security state
  // ----------------------------------------

  // Device lifecycle seen by the security core
  typedef enum logic [1:0] {
    DEVICE_UNPROVISIONED = 2'b00,
    DEVICE_MANUFACTURING = 2'b01,
    DEVICE_PRODUCTION    = 2'b11
  } device_lifecycle_e;

  typedef struct packed {
    device_lifecycle_e device_lifecycle;
    logic              debug_locked;
  } security_state_t;

  // Safe fallback, production with debug locked
  localparam security_state_t SecStateDefault = '{
    device_lifecycle: DEVICE_PRODUCTION,
    debug_locked:     1'b1
  };

  // Translator FSM states, all eight codes used
  typedef enum logic [2:0] {
    TRANSLATOR_RESET           = 3'd0,
    TRANSLATOR_IDLE            = 3'd1,
    TRANSLATOR_NON_DEBUG       = 3'd2,
    TRANSLATOR_UNPROV_DEBUG    = 3'd3,
    TRANSLATOR_MANUF_NON_DEBUG = 3'd4,
    TRANSLATOR_MANUF_DEBUG     = 3'd5,
    TRANSLATOR_PROD_NON_DEBUG  = 3'd6,
    TRANSLATOR_PROD_DEBUG      = 3'd7
  } translator_state_e;

  // Width defaults picked up by the top level
  localparam int unsigned UnlockLevelWidthDefault = 64;
  localparam int unsigned ZeroizeMaskWidthDefault = 32;

endpackage

`default_nettype wire

// File: common/unlock_if.sv
// Decoded unlock and scrap flags, driven by the unlock decoder and read by the translator and regs
`timescale 1ns/1ns
`default_nettype none

interface unlock_if;

  // Unlock level hit the DFT mask
  logic dft_unlock;
  // Unlock level hit the hardware debug (CLTAP) mask
  logic hw_debug_unlock;
  // Unlock level hit the production debug mask
  logic prod_debug_unlock;
  // Lifecycle controller is programming SCRAP
  logic scrap_req;

  // Decoder side
  modport source (output dft_unlock, hw_debug_unlock, prod_debug_unlock, scrap_req);

  // Consumer side
  modport sink (input dft_unlock, hw_debug_unlock, prod_debug_unlock, scrap_req);

endinterface

`default_nettype wire

// File: src/unlock_decode.sv
// Masks the debug unlock level into unlock flags and spots SCRAP program requests, all combinational
`timescale 1ns/1ns
`default_nettype none

module unlock_decode #(
  parameter int unsigned UnlockLevelWidth = security_pkg::UnlockLevelWidthDefault
) (
  // Unlock level from the security core
  input  wire logic [UnlockLevelWidth-1:0] unlock_level_i,
  // SoC supplied masks
  input  wire logic [UnlockLevelWidth-1:0] dft_mask_i,
  input  wire logic [UnlockLevelWidth-1:0] debug_unlock_mask_i,
  input  wire logic [UnlockLevelWidth-1:0] cltap_mask_i,
  // Program request from the lifecycle controller
  input  wire logic                        lc_prog_req_i,
  input  wire lcc_state_pkg::lc_state_e    lc_prog_state_i,
  // Decoded flags
  unlock_if.source                         unl
);

  import lcc_state_pkg::*;

  // ----------------------------------------
  // Masked unlock level
  // ----------------------------------------

  logic [UnlockLevelWidth-1:0] dft_masked;
  logic [UnlockLevelWidth-1:0] hw_dbg_masked;
  logic [UnlockLevelWidth-1:0] prod_dbg_masked;

  // Bitwise qualify the level with each mask
  assign dft_masked      = unlock_level_i & dft_mask_i;
  assign hw_dbg_masked   = unlock_level_i & cltap_mask_i;
  assign prod_dbg_masked = unlock_level_i & debug_unlock_mask_i;

  // Any surviving bit unlocks
  assign unl.dft_unlock        = |dft_masked;
  assign unl.hw_debug_unlock   = |hw_dbg_masked;
  assign unl.prod_debug_unlock = |prod_dbg_masked;

  // ----------------------------------------
  // Scrap detection
  // ----------------------------------------

  // Only a live request towards SCRAP counts
  assign unl.scrap_req = lc_prog_req_i && (lc_prog_state_i == LcStScrap);

endmodule

`default_nettype wire

// File: translator/state_translator.sv
// Translator FSM mapping the fuse lifecycle state to the registered core security state
`timescale 1ns/1ns
`default_nettype none

module state_translator (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  // Fuse data valid level, low holds the FSM in RESET
  input  wire logic                     otp_valid_i,
  // Invalid state error from the SoC
  input  wire logic                     state_error_i,
  // Warm reset about to hit, forces the default output
  input  wire logic                     early_warm_reset_warn_i,
  // Manufacturing debug enable from the security core
  input  wire logic                     manuf_dbg_enable_i,
  // Lifecycle state as read from fuses
  input  wire lcc_state_pkg::lc_state_e otp_state_i,
  unlock_if.sink                        unl,
  output security_pkg::security_state_t security_state_o
);

  import lcc_state_pkg::*;
  import security_pkg::*;

  translator_state_e state_q;
  translator_state_e state_d;
  lc_state_e         otp_state_q;
  security_state_t   sec_state_d;
  logic              lockdown;

  // Either cause sends every post-IDLE state to NON_DEBUG
  assign lockdown = state_error_i | unl.scrap_req;

  // ----------------------------------------
  // Next state
  // ----------------------------------------

  always_comb begin
    // Hold by default
    state_d = state_q;
    case (state_q)
      // Register only advances while valid is high
      TRANSLATOR_RESET: begin
        state_d = TRANSLATOR_IDLE;
      end
      // Decode the fuse state latched on the previous edge
      TRANSLATOR_IDLE: begin
        if (lockdown || otp_state_q == LcStScrap) begin
          state_d = TRANSLATOR_NON_DEBUG;
        end else if (otp_state_q == LcStRaw || lc_is_test_locked(otp_state_q)) begin
          state_d = TRANSLATOR_NON_DEBUG;
        end else if (lc_is_test_unlocked(otp_state_q)) begin
          state_d = TRANSLATOR_UNPROV_DEBUG;
        end else if (otp_state_q == LcStDev) begin
          state_d = TRANSLATOR_MANUF_NON_DEBUG;
        end else if (otp_state_q == LcStProd || otp_state_q == LcStProdEnd) begin
          state_d = TRANSLATOR_PROD_NON_DEBUG;
        end else if (otp_state_q == LcStRma) begin
          state_d = TRANSLATOR_PROD_DEBUG;
        end else begin
          // Unused encodings treated as locked
          state_d = TRANSLATOR_NON_DEBUG;
        end
      end
      // Sticky until valid drops
      TRANSLATOR_NON_DEBUG: begin
        state_d = TRANSLATOR_NON_DEBUG;
      end
      TRANSLATOR_MANUF_NON_DEBUG: begin
        if (lockdown) begin
          state_d = TRANSLATOR_NON_DEBUG;
        end else if (manuf_dbg_enable_i) begin
          state_d = TRANSLATOR_MANUF_DEBUG;
        end
      end
      TRANSLATOR_PROD_NON_DEBUG: begin
        if (lockdown) begin
          state_d = TRANSLATOR_NON_DEBUG;
        end else if (unl.prod_debug_unlock) begin
          state_d = TRANSLATOR_PROD_DEBUG;
        end
      end
      // Debug states only leave on lockdown
      TRANSLATOR_UNPROV_DEBUG, TRANSLATOR_MANUF_DEBUG, TRANSLATOR_PROD_DEBUG: begin
        if (lockdown) begin
          state_d = TRANSLATOR_NON_DEBUG;
        end
      end
      default: begin
        state_d = TRANSLATOR_NON_DEBUG;
      end
    endcase
  end

  // ----------------------------------------
  // Security state per FSM state
  // ----------------------------------------

  // Moore decode, lands one edge after the state register
  always_comb begin
    case (state_q)
      TRANSLATOR_UNPROV_DEBUG: begin
        sec_state_d = '{device_lifecycle: DEVICE_UNPROVISIONED, debug_locked: 1'b0};
      end
      TRANSLATOR_MANUF_NON_DEBUG: begin
        sec_state_d = '{device_lifecycle: DEVICE_MANUFACTURING, debug_locked: 1'b1};
      end
      TRANSLATOR_MANUF_DEBUG: begin
        sec_state_d = '{device_lifecycle: DEVICE_MANUFACTURING, debug_locked: 1'b0};
      end
      TRANSLATOR_PROD_DEBUG: begin
        sec_state_d = '{device_lifecycle: DEVICE_PRODUCTION, debug_locked: 1'b0};
      end
      // RESET, IDLE, NON_DEBUG, PROD_NON_DEBUG
      default: begin
        sec_state_d = SecStateDefault;
      end
    endcase
  end

  // ----------------------------------------
  // Registers
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= TRANSLATOR_RESET;
      otp_state_q      <= LcStRaw;
      security_state_o <= SecStateDefault;
    end else if (!otp_valid_i) begin
      // Fuse data not valid yet, park everything
      state_q          <= TRANSLATOR_RESET;
      otp_state_q      <= LcStRaw;
      security_state_o <= SecStateDefault;
    end else begin
      state_q          <= state_d;
      otp_state_q      <= otp_state_i;
      // Warm reset warning overrides the decoded value
      security_state_o <= early_warm_reset_warn_i ? SecStateDefault : sec_state_d;
    end
  end

endmodule

`default_nettype wire

// File: src/soc_control_regs.sv
// Registered SoC DFT and hardware debug enables plus the fuse zeroization command
`timescale 1ns/1ns
`default_nettype none

module soc_control_regs #(
  parameter int unsigned ZeroizeMaskWidth = security_pkg::ZeroizeMaskWidthDefault
) (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  // Fuse data valid level, low clears the enables
  input  wire logic                        otp_valid_i,
  // Lifecycle enable tokens
  input  wire lcc_state_pkg::lc_tx_t       lc_dft_en_i,
  input  wire lcc_state_pkg::lc_tx_t       lc_hw_debug_en_i,
  // Zeroization mask and PPD strap
  input  wire logic [ZeroizeMaskWidth-1:0] zeroize_mask_i,
  input  wire logic                        zeroize_ppd_i,
  unlock_if.sink                           unl,
  output logic                             soc_dft_en_o,
  output logic                             soc_hw_debug_en_o,
  output logic                             zeroize_cmd_o
);

  import lcc_state_pkg::*;

  logic dft_en_d;
  logic hw_debug_en_d;
  logic zeroize_d;

  // Token On or masked unlock, vetoed by a pending scrap
  function automatic logic enable_next(lc_tx_t token, logic unlock, logic scrap);
    return ((token == LcTxOn) || unlock) && !scrap;
  endfunction

  assign dft_en_d      = enable_next(lc_dft_en_i, unl.dft_unlock, unl.scrap_req);
  assign hw_debug_en_d = enable_next(lc_hw_debug_en_i, unl.hw_debug_unlock, unl.scrap_req);

  // Every mask bit set and PPD asserted
  assign zeroize_d = (&zeroize_mask_i) & zeroize_ppd_i;

  // ----------------------------------------
  // Output registers
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      soc_dft_en_o      <= 1'b0;
      soc_hw_debug_en_o <= 1'b0;
      zeroize_cmd_o     <= 1'b0;
    end else begin
      // Zeroization ignores valid
      zeroize_cmd_o <= zeroize_d;
      if (otp_valid_i) begin
        soc_dft_en_o      <= dft_en_d;
        soc_hw_debug_en_o <= hw_debug_en_d;
      end else begin
        soc_dft_en_o      <= 1'b0;
        soc_hw_debug_en_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/lcc_st_trans_top.sv
// Lifecycle state translator top level, plain ports around the decoder, translator FSM and regs
`timescale 1ns/1ns
`default_nettype none

module lcc_st_trans_top #(
  parameter int unsigned UnlockLevelWidth = security_pkg::UnlockLevelWidthDefault,
  parameter int unsigned ZeroizeMaskWidth = security_pkg::ZeroizeMaskWidthDefault
) (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  input  wire logic                        early_warm_reset_warn_i,
  input  wire logic                        state_error_i,
  // Fuse controller side
  input  wire logic                        otp_valid_i,
  input  wire lcc_state_pkg::lc_state_e    otp_state_i,
  // Lifecycle controller side
  input  wire logic                        lc_prog_req_i,
  input  wire lcc_state_pkg::lc_state_e    lc_prog_state_i,
  input  wire lcc_state_pkg::lc_tx_t       lc_dft_en_i,
  input  wire lcc_state_pkg::lc_tx_t       lc_hw_debug_en_i,
  // Security core side
  input  wire logic                        manuf_dbg_enable_i,
  input  wire logic [UnlockLevelWidth-1:0] unlock_level_i,
  // SoC masks
  input  wire logic [UnlockLevelWidth-1:0] dft_mask_i,
  input  wire logic [UnlockLevelWidth-1:0] debug_unlock_mask_i,
  input  wire logic [UnlockLevelWidth-1:0] cltap_mask_i,
  // Zeroization
  input  wire logic [ZeroizeMaskWidth-1:0] zeroize_mask_i,
  input  wire logic                        zeroize_ppd_i,
  output logic                             zeroize_cmd_o,
  // SoC enables and core security state
  output logic                             soc_dft_en_o,
  output logic                             soc_hw_debug_en_o,
  output security_pkg::security_state_t    security_state_o
);

  // Shared unlock and scrap flags
  unlock_if unl_if ();

  // Masking and scrap detection
  unlock_decode #(
    .UnlockLevelWidth(UnlockLevelWidth)
  ) u_unlock_decode (
    .unlock_level_i     (unlock_level_i),
    .dft_mask_i         (dft_mask_i),
    .debug_unlock_mask_i(debug_unlock_mask_i),
    .cltap_mask_i       (cltap_mask_i),
    .lc_prog_req_i      (lc_prog_req_i),
    .lc_prog_state_i    (lc_prog_state_i),
    .unl                (unl_if.source)
  );

  // Lifecycle to security state FSM
  state_translator u_state_translator (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .otp_valid_i            (otp_valid_i),
    .state_error_i          (state_error_i),
    .early_warm_reset_warn_i(early_warm_reset_warn_i),
    .manuf_dbg_enable_i     (manuf_dbg_enable_i),
    .otp_state_i            (otp_state_i),
    .unl                    (unl_if.sink),
    .security_state_o       (security_state_o)
  );

  // SoC enables and zeroization
  soc_control_regs #(
    .ZeroizeMaskWidth(ZeroizeMaskWidth)
  ) u_soc_control_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .otp_valid_i      (otp_valid_i),
    .lc_dft_en_i      (lc_dft_en_i),
    .lc_hw_debug_en_i (lc_hw_debug_en_i),
    .zeroize_mask_i   (zeroize_mask_i),
    .zeroize_ppd_i    (zeroize_ppd_i),
    .unl              (unl_if.sink),
    .soc_dft_en_o     (soc_dft_en_o),
    .soc_hw_debug_en_o(soc_hw_debug_en_o),
    .zeroize_cmd_o    (zeroize_cmd_o)
  );

endmodule

`default_nettype wire

// File: bench/lcc_st_trans_props.sv
// Port level checks bound into the translator top level, compiled with the testbench
`timescale 1ns/1ns
`default_nettype none

module lcc_st_trans_props #(
  parameter int unsigned UnlockLevelWidth = security_pkg::UnlockLevelWidthDefault
) (
  input wire logic                          clk_i,
  input wire logic                          rst_ni,
  input wire lcc_state_pkg::lc_tx_t         lc_dft_en_i,
  input wire lcc_state_pkg::lc_tx_t         lc_hw_debug_en_i,
  input wire logic [UnlockLevelWidth-1:0]   unlock_level_i,
  input wire logic [UnlockLevelWidth-1:0]   dft_mask_i,
  input wire logic [UnlockLevelWidth-1:0]   cltap_mask_i,
  input wire security_pkg::security_state_t security_state_o,
  input wire logic                          soc_dft_en_o,
  input wire logic                          soc_hw_debug_en_o,
  input wire logic                          zeroize_cmd_o
);

  import lcc_state_pkg::*;
  import security_pkg::*;

  // Number of failed checks
  int fail_count = 0;

  logic dft_closed;
  logic hw_closed;

  // Neither token On nor masked unlock
  assign dft_closed = (lc_dft_en_i != LcTxOn) && !(|(unlock_level_i & dft_mask_i));
  assign hw_closed  = (lc_hw_debug_en_i != LcTxOn) && !(|(unlock_level_i & cltap_mask_i));

  // ----------------------------------------
  // Default state keeps closed enables low
  // ----------------------------------------

  dft_gated: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (security_state_o == SecStateDefault) && $past(dft_closed) |-> !soc_dft_en_o)
    else begin
      $error("soc_dft_en_o high in the default state without token or unlock");
      fail_count++;
    end

  hw_gated: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (security_state_o == SecStateDefault) && $past(hw_closed) |-> !soc_hw_debug_en_o)
    else begin
      $error("soc_hw_debug_en_o high in the default state without token or unlock");
      fail_count++;
    end

  // ----------------------------------------
  // Reset clears every control output
  // ----------------------------------------

  reset_low: assert property (@(posedge clk_i)
      !rst_ni |=> (!soc_dft_en_o && !soc_hw_debug_en_o && !zeroize_cmd_o))
    else begin
      $error("enable or zeroize output high while in reset");
      fail_count++;
    end

endmodule

bind lcc_st_trans_top lcc_st_trans_props #(
  .UnlockLevelWidth(UnlockLevelWidth)
) props_inst (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .lc_dft_en_i      (lc_dft_en_i),
  .lc_hw_debug_en_i (lc_hw_debug_en_i),
  .unlock_level_i   (unlock_level_i),
  .dft_mask_i       (dft_mask_i),
  .cltap_mask_i     (cltap_mask_i),
  .security_state_o (security_state_o),
  .soc_dft_en_o     (soc_dft_en_o),
  .soc_hw_debug_en_o(soc_hw_debug_en_o),
  .zeroize_cmd_o    (zeroize_cmd_o)
);

`default_nettype wire

// File: bench/tb_lcc_st_trans.sv
// Testbench for the lifecycle state translator top level, run as the simulation top
`timescale 1ns/1ns
`default_nettype none

module tb_lcc_st_trans;

  import lcc_state_pkg::*;
  import security_pkg::*;

  localparam int ClkPeriod = 4;
  // Reset plus the six tests, in clock cycles as the stimulus below spends them
  localparam int TestCycles = 16 + 8 + 21 * 7 + 3 * 8 + 3 * 24 + 13 + 44 + 32;

  // Translator model states
  typedef enum logic [2:0] {
    MDL_RESET, MDL_IDLE, MDL_LOCKED, MDL_UNPROV_DBG,
    MDL_MANUF, MDL_MANUF_DBG, MDL_PROD, MDL_PROD_DBG
  } mdl_state_e;

  logic clk_i, rst_ni;
  logic early_warm_reset_warn_i, state_error_i, otp_valid_i, manuf_dbg_enable_i;
  lc_state_e otp_state_i, lc_prog_state_i;
  logic lc_prog_req_i;
  lc_tx_t lc_dft_en_i, lc_hw_debug_en_i;
  logic [UnlockLevelWidthDefault-1:0] unlock_level_i, dft_mask_i, debug_unlock_mask_i;
  logic [UnlockLevelWidthDefault-1:0] cltap_mask_i;
  logic [ZeroizeMaskWidthDefault-1:0] zeroize_mask_i;
  logic zeroize_ppd_i, zeroize_cmd_o, soc_dft_en_o, soc_hw_debug_en_o;
  security_state_t security_state_o;

  // Model state and expected outputs
  mdl_state_e mdl_state;
  logic [4:0] mdl_fuse;
  security_state_t exp_sec;
  logic exp_dft, exp_hw, exp_zeroize;
  logic scrap, lockdown, dft_unlock, hw_unlock, prod_unlock;

  logic [31:0] lfsr;
  int errors, err_mark, tests_run, tests_failed;
  string test_name;

  lcc_st_trans_top #(
    .UnlockLevelWidth(UnlockLevelWidthDefault),
    .ZeroizeMaskWidth(ZeroizeMaskWidthDefault)
  ) lcc_st_trans_top_inst (.*);

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  assign scrap       = lc_prog_req_i && (lc_prog_state_i == LcStScrap);
  assign lockdown    = state_error_i || scrap;
  assign dft_unlock  = |(unlock_level_i & dft_mask_i);
  assign hw_unlock   = |(unlock_level_i & cltap_mask_i);
  assign prod_unlock = |(unlock_level_i & debug_unlock_mask_i);

  // Fuse code to first state after IDLE
  function automatic mdl_state_e target_of(logic [4:0] fuse);
    // Odd codes 1 to 15 are the TEST_UNLOCKED states
    if (fuse >= 5'd1 && fuse <= 5'd15 && fuse[0]) return MDL_UNPROV_DBG;
    if (fuse == LcStDev) return MDL_MANUF;
    if (fuse == LcStProd || fuse == LcStProdEnd) return MDL_PROD;
    if (fuse == LcStRma) return MDL_PROD_DBG;
    // RAW, TEST_LOCKED, SCRAP and unused codes
    return MDL_LOCKED;
  endfunction

  function automatic mdl_state_e next_mdl(mdl_state_e cur, logic [4:0] fuse, logic lock,
                                          logic manuf, logic prod_unl);
    mdl_state_e nxt;
    nxt = cur;
    if (cur == MDL_RESET) nxt = MDL_IDLE;
    else if (lock || cur == MDL_LOCKED) nxt = MDL_LOCKED;
    else if (cur == MDL_IDLE) nxt = target_of(fuse);
    else if (cur == MDL_MANUF && manuf) nxt = MDL_MANUF_DBG;
    else if (cur == MDL_PROD && prod_unl) nxt = MDL_PROD_DBG;
    return nxt;
  endfunction

  function automatic security_state_t sec_for(mdl_state_e st);
    security_state_t s;
    case (st)
      MDL_UNPROV_DBG: s = '{DEVICE_UNPROVISIONED, 1'b0};
      MDL_MANUF:      s = '{DEVICE_MANUFACTURING, 1'b1};
      MDL_MANUF_DBG:  s = '{DEVICE_MANUFACTURING, 1'b0};
      MDL_PROD_DBG:   s = '{DEVICE_PRODUCTION, 1'b0};
      default:        s = SecStateDefault;
    endcase
    return s;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mdl_state   <= MDL_RESET;
      mdl_fuse    <= '0;
      exp_sec     <= SecStateDefault;
      exp_dft     <= 1'b0;
      exp_hw      <= 1'b0;
      exp_zeroize <= 1'b0;
    end else begin
      // Zeroization does not look at valid
      exp_zeroize <= (&zeroize_mask_i) && zeroize_ppd_i;
      if (!otp_valid_i) begin
        mdl_state <= MDL_RESET;
        exp_sec   <= SecStateDefault;
        exp_dft   <= 1'b0;
        exp_hw    <= 1'b0;
      end else begin
        mdl_state <= next_mdl(mdl_state, mdl_fuse, lockdown, manuf_dbg_enable_i, prod_unlock);
        mdl_fuse  <= otp_state_i;
        exp_sec   <= early_warm_reset_warn_i ? SecStateDefault : sec_for(mdl_state);
        exp_dft   <= (lc_dft_en_i == LcTxOn || dft_unlock) && !scrap;
        exp_hw    <= (lc_hw_debug_en_i == LcTxOn || hw_unlock) && !scrap;
      end
    end
  end

  // ----------------------------------------
  // Checks against the model
  // ----------------------------------------

  sec_state_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
      security_state_o == exp_sec)
    else value_error($sformatf("security_state_o is %b, expected %b",
                               $sampled(security_state_o), $sampled(exp_sec)));
  dft_en_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
      soc_dft_en_o == exp_dft)
    else value_error($sformatf("soc_dft_en_o is %b, expected %b",
                               $sampled(soc_dft_en_o), $sampled(exp_dft)));
  hw_en_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
      soc_hw_debug_en_o == exp_hw)
    else value_error($sformatf("soc_hw_debug_en_o is %b, expected %b",
                               $sampled(soc_hw_debug_en_o), $sampled(exp_hw)));
  zeroize_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
      zeroize_cmd_o == exp_zeroize)
    else value_error($sformatf("zeroize_cmd_o is %b, expected %b",
                               $sampled(zeroize_cmd_o), $sampled(exp_zeroize)));

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  task automatic value_error(string msg);
    $display("FAILED %0t ns: %s", $time, msg);
    errors++;
  endtask

  function automatic int error_total();
    return errors + lcc_st_trans_top_inst.props_inst.fail_count;
  endfunction

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] random_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic tick(int n);
    repeat (n) @(negedge clk_i);
  endtask

  // Drop valid for two cycles, then present a new fuse state
  task automatic enter_state(lc_state_e st, int hold);
    otp_valid_i = 1'b0;
    tick(2);
    otp_state_i = st;
    otp_valid_i = 1'b1;
    tick(hold);
  endtask

  // Error pulse, then scrap request, each from a fresh start in st
  task automatic lockdown_round(lc_state_e st);
    enter_state(st, 5);
    state_error_i = 1'b1;
    tick(1);
    state_error_i = 1'b0;
    tick(4);
    enter_state(st, 5);
    lc_prog_req_i   = 1'b1;
    lc_prog_state_i = LcStScrap;
    tick(1);
    lc_prog_req_i = 1'b0;
    tick(4);
  endtask

  task automatic begin_test(string name);
    test_name = name;
    err_mark  = error_total();
  endtask

  task automatic end_test();
    int n;
    n = error_total() - err_mark;
    tests_run++;
    if (n == 0) begin
      $display("Test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", test_name, n);
    end
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  initial begin
    clk_i                   = 1'b0;
    rst_ni                  = 1'b0;
    early_warm_reset_warn_i = 1'b0;
    state_error_i           = 1'b0;
    otp_valid_i             = 1'b0;
    otp_state_i             = LcStRaw;
    lc_prog_req_i           = 1'b0;
    lc_prog_state_i         = LcStRaw;
    lc_dft_en_i             = LcTxOff;
    lc_hw_debug_en_i        = LcTxOff;
    manuf_dbg_enable_i      = 1'b0;
    unlock_level_i          = '0;
    dft_mask_i              = '0;
    debug_unlock_mask_i     = '0;
    cltap_mask_i            = '0;
    zeroize_mask_i          = '0;
    zeroize_ppd_i           = 1'b0;
    lfsr                    = 32'd74617;
    errors                  = 0;
    tests_run               = 0;
    tests_failed            = 0;
    tick(16);
    rst_ni = 1'b1;

    // Tokens On must not leak while fuse data is invalid
    begin_test("reset and valid low");
    lc_dft_en_i      = LcTxOn;
    lc_hw_debug_en_i = LcTxOn;
    tick(8);
    lc_dft_en_i      = LcTxOff;
    lc_hw_debug_en_i = LcTxOff;
    end_test();

    begin_test("lifecycle state map");
    for (int s = 0; s <= LcStScrap; s++) begin
      enter_state(lc_state_e'(s), 5);
    end
    end_test();

    begin_test("debug unlock");
    manuf_dbg_enable_i = 1'b1;
    enter_state(LcStDev, 6);
    manuf_dbg_enable_i  = 1'b0;
    unlock_level_i      = random_bits(64);
    debug_unlock_mask_i = random_bits(64);
    // Need at least one overlapping bit
    if ((unlock_level_i & debug_unlock_mask_i) == '0) debug_unlock_mask_i = unlock_level_i;
    enter_state(LcStProd, 6);
    enter_state(LcStProdEnd, 6);
    unlock_level_i      = '0;
    debug_unlock_mask_i = '0;
    end_test();

    begin_test("lockdown and warm reset");
    manuf_dbg_enable_i = 1'b1;
    lockdown_round(LcStTestUnlocked3);
    lockdown_round(LcStDev);
    lockdown_round(LcStRma);
    enter_state(LcStRma, 5);
    early_warm_reset_warn_i = 1'b1;
    tick(3);
    early_warm_reset_warn_i = 1'b0;
    tick(3);
    end_test();

    begin_test("soc enables");
    enter_state(LcStDev, 2);
    lc_prog_state_i = LcStScrap;
    for (int i = 0; i < 40; i++) begin
      lc_dft_en_i      = (random_bits(1) != '0) ? LcTxOn : lc_tx_t'(random_bits(4));
      lc_hw_debug_en_i = (random_bits(1) != '0) ? LcTxOn : lc_tx_t'(random_bits(4));
      // Single hot level so the masked result goes both ways
      unlock_level_i   = 64'd1 << random_bits(6);
      dft_mask_i       = random_bits(64);
      cltap_mask_i     = random_bits(64);
      lc_prog_req_i    = random_bits(3) == '0;
      otp_valid_i      = random_bits(4) != '0;
      tick(1);
    end
    lc_dft_en_i      = LcTxOff;
    lc_hw_debug_en_i = LcTxOff;
    unlock_level_i   = '0;
    lc_prog_req_i    = 1'b0;
    end_test();

    begin_test("zeroization");
    for (int i = 0; i < 30; i++) begin
      zeroize_mask_i = (random_bits(1) != '0) ? '1
                       : ZeroizeMaskWidthDefault'(random_bits(ZeroizeMaskWidthDefault));
      zeroize_ppd_i  = random_bits(1) != '0;
      otp_valid_i    = random_bits(1) != '0;
      tick(1);
    end
    zeroize_ppd_i = 1'b0;
    tick(2);
    end_test();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_total());
    if (error_total() == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Twice the planned run length
  initial begin
    #(2 * TestCycles * ClkPeriod);
    $display("Watchdog expired, tests did not finish within %0d ns", 2 * TestCycles * ClkPeriod);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
common/lcc_state_pkg.sv
common/security_pkg.sv
common/unlock_if.sv
src/unlock_decode.sv
translator/state_translator.sv
src/soc_control_regs.sv
src/lcc_st_trans_top.sv
bench/lcc_st_trans_props.sv
bench/tb_lcc_st_trans.sv

// File: run_sim.sh
#!/bin/sh
# Build the translator testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --assert --timing --top-module tb_lcc_st_trans -f verilog.f -o sim_bin
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_bin +verilator+error+limit+1000 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
  exit 1
fi

if grep -qx "SIMULATION PASSED" "$LOG"; then
  exit 0
fi
exit 1
